//--- ipod_pkg.sv
`default_nettype none

package ipod_pkg;

  // ========================================
  // Data widths
  // ========================================
  typedef logic [22:0] word_addr_t;
  typedef logic [31:0] flash_word_t;
  typedef logic [7:0]  sample_t;
  typedef logic [1:0]  lane_t;
  typedef logic [23:0] half_count_t;
  typedef logic [3:0]  hex_digit_t;
  typedef logic [6:0]  seg_t;

  // ASCII command codes
  localparam logic [7:0] CMD_PLAY     = 8'h45;
  localparam logic [7:0] CMD_PAUSE    = 8'h44;
  localparam logic [7:0] CMD_FORWARD  = 8'h46;
  localparam logic [7:0] CMD_BACKWARD = 8'h42;
  localparam logic [7:0] CMD_RESTART  = 8'h52;

  localparam int NUM_DIGITS = 6;

  // ========================================
  // Defaults for the top level
  // ========================================
  // 1136 cycles per half period is roughly 22 kHz at 50 MHz
  localparam half_count_t DEFAULT_HALF_COUNT = 24'd1136;
  localparam half_count_t SPEED_STEP         = 24'd100;
  localparam half_count_t HALF_COUNT_MIN     = 24'd200;
  localparam half_count_t HALF_COUNT_MAX     = 24'd4000;
  localparam int          REPEAT_CYCLES      = 5_000_000;
  localparam int          REFRESH_CYCLES     = 25_000_000;
  localparam word_addr_t  LAST_WORD_ADDR     = 23'h7FFFF;

endpackage

`default_nettype wire

//--- player_if.sv
`timescale 1ns/1ps
`default_nettype none

interface player_if;

  logic playing;
  logic forward;
  logic restart;
  logic tick;

  // Command side
  modport ctrl (output playing, output forward, output restart);

  // Rate side
  modport tick_src (output tick);

  // Consumer sees everything
  modport fetch (input playing, input forward, input restart, input tick);

endinterface

`default_nettype wire

//--- player_control.sv
`timescale 1ns/1ps
`default_nettype none

module player_control (
  input  wire         CLK_50M,
  input  wire         rst_n,
  input  wire         cmd_valid,
  input  wire  [7:0]  cmd_ascii,
  player_if.ctrl      ctrl
);

  // ========================================
  // Command register set
  // ========================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ctrl.playing <= 1'b0;
      ctrl.forward <= 1'b1;
      ctrl.restart <= 1'b0;
    end
    else
    begin
      ctrl.restart <= 1'b0;
      if (cmd_valid)
      begin
        case (cmd_ascii)
          ipod_pkg::CMD_PLAY:
            ctrl.playing <= 1'b1;
          ipod_pkg::CMD_PAUSE:
            ctrl.playing <= 1'b0;
          ipod_pkg::CMD_FORWARD:
            ctrl.forward <= 1'b1;
          ipod_pkg::CMD_BACKWARD:
            ctrl.forward <= 1'b0;
          // Direction is left as it is
          ipod_pkg::CMD_RESTART:
            ctrl.restart <= 1'b1;
          default:
            ; // other keys do nothing
        endcase
      end
    end
  end

  // Fetcher relies on restart being a one-cycle pulse
  restart_single_pulse: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    ctrl.restart |=> !ctrl.restart
  );

endmodule

`default_nettype wire

//--- speed_regulator.sv
`timescale 1ns/1ps
`default_nettype none

module speed_regulator #(
  parameter ipod_pkg::half_count_t DEFAULT_HALF_COUNT = ipod_pkg::DEFAULT_HALF_COUNT,
  parameter ipod_pkg::half_count_t SPEED_STEP         = ipod_pkg::SPEED_STEP,
  parameter ipod_pkg::half_count_t HALF_COUNT_MIN     = ipod_pkg::HALF_COUNT_MIN,
  parameter ipod_pkg::half_count_t HALF_COUNT_MAX     = ipod_pkg::HALF_COUNT_MAX,
  parameter int                    REPEAT_CYCLES      = ipod_pkg::REPEAT_CYCLES
) (
  input  wire                   CLK_50M,
  input  wire                   rst_n,
  input  wire                   key_speed_up,
  input  wire                   key_speed_down,
  input  wire                   key_speed_reset,
  output ipod_pkg::half_count_t half_count
);

  localparam int RPT_W = $clog2(REPEAT_CYCLES);

  logic [2:0]            keys;
  logic [2:0]            keys_q;
  logic                  key_rise;
  logic                  key_held;
  logic                  repeat_due;
  logic [RPT_W-1:0]      repeat_cnt;
  ipod_pkg::half_count_t stepped;

  assign keys       = {key_speed_reset, key_speed_up, key_speed_down};
  assign key_rise   = |(keys & ~keys_q);
  assign key_held   = |keys;
  assign repeat_due = (repeat_cnt == RPT_W'(REPEAT_CYCLES - 1));

  // Reset wins over up, up over down
  always_comb
  begin
    stepped = half_count;
    if (key_speed_reset)
      stepped = DEFAULT_HALF_COUNT;
    else if (key_speed_up)
    begin
      if (half_count < HALF_COUNT_MIN + SPEED_STEP)
        stepped = HALF_COUNT_MIN;
      else
        stepped = half_count - SPEED_STEP;
    end
    else if (key_speed_down)
    begin
      if (half_count > HALF_COUNT_MAX - SPEED_STEP)
        stepped = HALF_COUNT_MAX;
      else
        stepped = half_count + SPEED_STEP;
    end
  end

  // ========================================
  // Edge step plus auto-repeat
  // ========================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      keys_q     <= '0;
      repeat_cnt <= '0;
      half_count <= DEFAULT_HALF_COUNT;
    end
    else
    begin
      keys_q <= keys;
      if (key_rise)
      begin
        repeat_cnt <= '0;
        half_count <= stepped;
      end
      else if (key_held)
      begin
        if (repeat_due)
        begin
          repeat_cnt <= '0;
          half_count <= stepped;
        end
        else
          repeat_cnt <= repeat_cnt + 1'b1;
      end
      else
        repeat_cnt <= '0;
    end
  end

  count_in_range: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    (half_count >= HALF_COUNT_MIN) && (half_count <= HALF_COUNT_MAX)
  );

endmodule

`default_nettype wire

//--- sample_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module sample_tick_gen (
  input  wire                   CLK_50M,
  input  wire                   rst_n,
  input  wire ipod_pkg::half_count_t half_count,
  player_if.tick_src            tk
);

  // One extra bit holds twice the half period
  localparam int CNT_W = $bits(ipod_pkg::half_count_t) + 1;

  logic [CNT_W-1:0] period_cnt;

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      period_cnt <= '0;
      tk.tick    <= 1'b0;
    end
    else if (period_cnt == '0)
    begin
      // New count is picked up only here
      period_cnt <= {half_count, 1'b0} - 1'b1;
      tk.tick    <= 1'b1;
    end
    else
    begin
      period_cnt <= period_cnt - 1'b1;
      tk.tick    <= 1'b0;
    end
  end

  tick_single_pulse: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    tk.tick |=> !tk.tick
  );

endmodule

`default_nettype wire

//--- flash_sample_fetcher.sv
`timescale 1ns/1ps
`default_nettype none

module flash_sample_fetcher #(
  parameter ipod_pkg::word_addr_t LAST_WORD_ADDR = ipod_pkg::LAST_WORD_ADDR
) (
  input  wire                        CLK_50M,
  input  wire                        rst_n,
  player_if.fetch                    pl,
  output logic                       flash_read,
  output ipod_pkg::word_addr_t       flash_address,
  input  wire                        flash_waitrequest,
  input  wire ipod_pkg::flash_word_t flash_readdata,
  input  wire                        flash_readdatavalid,
  output logic                       sample_valid,
  output ipod_pkg::sample_t          sample_data
);

  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT} state_t;

  state_t               state;
  ipod_pkg::word_addr_t addr;
  ipod_pkg::lane_t      lane;
  logic                 discard;
  logic                 start_read;
  logic                 in_flight;
  logic                 accept;
  ipod_pkg::word_addr_t restart_addr;
  ipod_pkg::lane_t      restart_lane;

  // Start of the song in the current direction
  assign restart_addr = pl.forward ? '0 : LAST_WORD_ADDR;
  assign restart_lane = pl.forward ? ipod_pkg::lane_t'(0) : ipod_pkg::lane_t'(3);

  // Ticks outside idle are simply lost
  assign start_read = (state == ST_IDLE) && pl.tick && pl.playing;
  assign in_flight  = (state == ST_REQ) || ((state == ST_WAIT) && !flash_readdatavalid);
  assign accept     = (state == ST_WAIT) && flash_readdatavalid && !discard && !pl.restart;

  // ========================================
  // Read FSM and play position
  // ========================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= ST_IDLE;
      flash_read   <= 1'b0;
      addr         <= '0;
      lane         <= '0;
      discard      <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= accept;

      case (state)
        ST_IDLE:
          if (start_read)
          begin
            flash_read <= 1'b1;
            state      <= ST_REQ;
          end
        ST_REQ:
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state      <= ST_WAIT;
          end
        ST_WAIT:
          if (flash_readdatavalid)
          begin
            discard <= 1'b0;
            state   <= ST_IDLE;
          end
        default:
          state <= ST_IDLE;
      endcase

      if (pl.restart)
      begin
        addr <= restart_addr;
        lane <= restart_lane;
        // Old read still finishes, its byte is dropped
        if (in_flight)
          discard <= 1'b1;
      end
      else if (accept)
      begin
        if (pl.forward)
        begin
          lane <= lane + 1'b1;
          if (lane == 2'd3)
            addr <= (addr == LAST_WORD_ADDR) ? '0 : addr + 1'b1;
        end
        else
        begin
          lane <= lane - 1'b1;
          if (lane == 2'd0)
            addr <= (addr == '0) ? LAST_WORD_ADDR : addr - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (start_read)
      flash_address <= pl.restart ? restart_addr : addr;
    if (accept)
      sample_data <= flash_readdata[{lane, 3'b000} +: 8];
  end

  // Avalon hold rule while the slave stalls
  addr_held_on_wait: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    (flash_read && flash_waitrequest) |=> (flash_read && $stable(flash_address))
  );

endmodule

`default_nettype wire

//--- display_refresh.sv
`timescale 1ns/1ps
`default_nettype none

module display_refresh #(
  parameter int REFRESH_CYCLES = ipod_pkg::REFRESH_CYCLES
) (
  input  wire                        CLK_50M,
  input  wire                        rst_n,
  input  wire ipod_pkg::half_count_t half_count,
  output ipod_pkg::hex_digit_t       digits [ipod_pkg::NUM_DIGITS]
);

  localparam int REF_W = $clog2(REFRESH_CYCLES);

  logic [REF_W-1:0]      refresh_cnt;
  ipod_pkg::half_count_t shown;

  // Zero right after reset, so the first latch is immediate
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      refresh_cnt <= '0;
    else if (refresh_cnt == REF_W'(REFRESH_CYCLES - 1))
      refresh_cnt <= '0;
    else
      refresh_cnt <= refresh_cnt + 1'b1;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (refresh_cnt == '0)
      shown <= half_count;
  end

  // Digit 0 is the low nibble
  always_comb
  begin
    for (int i = 0; i < ipod_pkg::NUM_DIGITS; i++)
      digits[i] = shown[4*i +: 4];
  end

endmodule

`default_nettype wire

//--- hex_digit_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module hex_digit_decoder (
  input  wire                       CLK_50M,
  input  wire                       rst_n,
  input  wire ipod_pkg::hex_digit_t digit,
  output ipod_pkg::seg_t            seg
);

  // Bit 0 is segment a, a low bit lights the segment
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      seg <= 7'h7F;
    else
    begin
      case (digit)
        4'h0:    seg <= 7'b1000000;
        4'h1:    seg <= 7'b1111001;
        4'h2:    seg <= 7'b0100100;
        4'h3:    seg <= 7'b0110000;
        4'h4:    seg <= 7'b0011001;
        4'h5:    seg <= 7'b0010010;
        4'h6:    seg <= 7'b0000010;
        4'h7:    seg <= 7'b1111000;
        4'h8:    seg <= 7'b0000000;
        4'h9:    seg <= 7'b0010000;
        4'hA:    seg <= 7'b0001000;
        4'hB:    seg <= 7'b0000011;
        4'hC:    seg <= 7'b1000110;
        4'hD:    seg <= 7'b0100001;
        4'hE:    seg <= 7'b0000110;
        default: seg <= 7'b0001110;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- ipod_top.sv
`timescale 1ns/1ps
`default_nettype none

module ipod_top #(
  parameter ipod_pkg::half_count_t DEFAULT_HALF_COUNT = ipod_pkg::DEFAULT_HALF_COUNT,
  parameter ipod_pkg::half_count_t SPEED_STEP         = ipod_pkg::SPEED_STEP,
  parameter ipod_pkg::half_count_t HALF_COUNT_MIN     = ipod_pkg::HALF_COUNT_MIN,
  parameter ipod_pkg::half_count_t HALF_COUNT_MAX     = ipod_pkg::HALF_COUNT_MAX,
  parameter int                    REPEAT_CYCLES      = ipod_pkg::REPEAT_CYCLES,
  parameter int                    REFRESH_CYCLES     = ipod_pkg::REFRESH_CYCLES,
  parameter ipod_pkg::word_addr_t  LAST_WORD_ADDR     = ipod_pkg::LAST_WORD_ADDR
) (
  input  wire                        CLK_50M,
  input  wire                        rst_n,
  input  wire                        cmd_valid,
  input  wire [7:0]                  cmd_ascii,
  input  wire                        key_speed_up,
  input  wire                        key_speed_down,
  input  wire                        key_speed_reset,
  output logic                       flash_read,
  output ipod_pkg::word_addr_t       flash_address,
  input  wire                        flash_waitrequest,
  input  wire ipod_pkg::flash_word_t flash_readdata,
  input  wire                        flash_readdatavalid,
  output logic                       sample_valid,
  output ipod_pkg::sample_t          sample_data,
  output ipod_pkg::seg_t             hex0,
  output ipod_pkg::seg_t             hex1,
  output ipod_pkg::seg_t             hex2,
  output ipod_pkg::seg_t             hex3,
  output ipod_pkg::seg_t             hex4,
  output ipod_pkg::seg_t             hex5
);

  ipod_pkg::half_count_t half_count;
  ipod_pkg::hex_digit_t  digits [ipod_pkg::NUM_DIGITS];
  ipod_pkg::seg_t        segs   [ipod_pkg::NUM_DIGITS];

  player_if pl ();

  // ========================================
  // Playback path
  // ========================================
  player_control player_control_i (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_ascii (cmd_ascii),
    .ctrl      (pl.ctrl)
  );

  speed_regulator #(
    .DEFAULT_HALF_COUNT (DEFAULT_HALF_COUNT),
    .SPEED_STEP         (SPEED_STEP),
    .HALF_COUNT_MIN     (HALF_COUNT_MIN),
    .HALF_COUNT_MAX     (HALF_COUNT_MAX),
    .REPEAT_CYCLES      (REPEAT_CYCLES)
  ) speed_regulator_i (
    .CLK_50M         (CLK_50M),
    .rst_n           (rst_n),
    .key_speed_up    (key_speed_up),
    .key_speed_down  (key_speed_down),
    .key_speed_reset (key_speed_reset),
    .half_count      (half_count)
  );

  sample_tick_gen sample_tick_gen_i (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .half_count (half_count),
    .tk         (pl.tick_src)
  );

  flash_sample_fetcher #(
    .LAST_WORD_ADDR (LAST_WORD_ADDR)
  ) flash_sample_fetcher_i (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .pl                  (pl.fetch),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample_valid        (sample_valid),
    .sample_data         (sample_data)
  );

  // ========================================
  // Speed display
  // ========================================
  display_refresh #(
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) display_refresh_i (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .half_count (half_count),
    .digits     (digits)
  );

  for (genvar i = 0; i < ipod_pkg::NUM_DIGITS; i++)
  begin : g_hex
    hex_digit_decoder hex_digit_decoder_i (
      .CLK_50M (CLK_50M),
      .rst_n   (rst_n),
      .digit   (digits[i]),
      .seg     (segs[i])
    );
  end

  assign hex0 = segs[0];
  assign hex1 = segs[1];
  assign hex2 = segs[2];
  assign hex3 = segs[3];
  assign hex4 = segs[4];
  assign hex5 = segs[5];

endmodule

`default_nettype wire

//--- tb_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_flash_model (
  input  wire                         CLK_50M,
  input  wire                         rst_n,
  input  wire                         read,
  input  wire  ipod_pkg::word_addr_t  address,
  output logic                        waitrequest,
  output ipod_pkg::flash_word_t       readdata,
  output logic                        readdatavalid,
  output int                          protocol_errors
);

  logic [31:0]           lfsr;
  logic [1:0]            wait_left;
  logic                  accept;
  logic [1:0]            valid_pipe;
  ipod_pkg::flash_word_t data_pipe [2];
  ipod_pkg::word_addr_t  addr_q;
  logic                  stalled_q;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] x);
    return {x[30:0], x[31] ^ x[21] ^ x[1] ^ x[0]};
  endfunction

  // Byte k of word a holds the low byte of 4a+k
  function automatic ipod_pkg::flash_word_t word_at(input ipod_pkg::word_addr_t a);
    ipod_pkg::flash_word_t w;
    for (int k = 0; k < 4; k++)
      w[8*k +: 8] = 8'((4 * int'(a)) + k);
    return w;
  endfunction

  assign waitrequest   = read && (wait_left != 2'd0);
  assign accept        = read && (wait_left == 2'd0);
  assign readdatavalid = valid_pipe[1];
  assign readdata      = data_pipe[1];

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      lfsr            <= 32'hcb8a_100d;
      wait_left       <= 2'd1;
      valid_pipe      <= '0;
      data_pipe[0]    <= '0;
      data_pipe[1]    <= '0;
      addr_q          <= '0;
      stalled_q       <= 1'b0;
      protocol_errors <= 0;
    end
    else
    begin
      valid_pipe   <= {valid_pipe[0], accept};
      data_pipe[1] <= data_pipe[0];
      addr_q       <= address;
      stalled_q    <= waitrequest;
      if (accept)
      begin
        data_pipe[0] <= word_at(address);
        // Two bits, one LFSR step each, give 1 to 3 wait cycles
        lfsr         <= lfsr_step(lfsr_step(lfsr));
        wait_left    <= 2'd1 + 2'(lfsr[1:0] % 3);
      end
      else if (waitrequest)
        wait_left <= wait_left - 1'b1;

      if (read && (valid_pipe != 2'b00))
      begin
        $display("Flash model: a read was issued while another read was outstanding");
        protocol_errors <= protocol_errors + 1;
      end
      // A stalled read must stay up with the same address
      if (stalled_q && (!read || (address != addr_q)))
      begin
        $display("Flash model: the read or its address changed while the read was stalled");
        protocol_errors <= protocol_errors + 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_ipod.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ipod;

  localparam int HC0     = 40;
  localparam int STEP    = 8;
  localparam int HC_MIN  = 16;
  localparam int HC_MAX  = 80;
  localparam int REPEAT  = 200;
  localparam int REFRESH = 50;
  localparam int LIMIT   = 20000;

  logic CLK_50M = 1'b0;
  logic rst_n;
  logic cmd_valid;
  logic [7:0] cmd_ascii;
  logic key_speed_up;
  logic key_speed_down;
  logic key_speed_reset;
  logic flash_read;
  logic flash_waitrequest;
  logic flash_readdatavalid;
  logic sample_valid;
  ipod_pkg::word_addr_t  flash_address;
  ipod_pkg::flash_word_t flash_readdata;
  ipod_pkg::sample_t     sample_data;
  ipod_pkg::seg_t        hex0;
  ipod_pkg::seg_t        hex1;
  ipod_pkg::seg_t        hex2;
  ipod_pkg::seg_t        hex3;
  ipod_pkg::seg_t        hex4;
  ipod_pkg::seg_t        hex5;

  int errors = 0;
  int protocol_errors;
  int cycles = 0;
  int tb_hc = HC0;
  int gap;
  int idle_cnt;
  logic [5:0] exp_pos;
  logic tb_fwd;
  logic tb_play;
  logic ever_played;
  logic rst_d1;
  logic fwd_d1;
  logic bwd_d1;
  logic steady = 1'b0;
  logic have_prev;
  logic disp_check = 1'b0;
  logic gap_ok;

  always #10 CLK_50M = ~CLK_50M;

  ipod_top #(
    .DEFAULT_HALF_COUNT (24'(HC0)),
    .SPEED_STEP         (24'(STEP)),
    .HALF_COUNT_MIN     (24'(HC_MIN)),
    .HALF_COUNT_MAX     (24'(HC_MAX)),
    .REPEAT_CYCLES      (REPEAT),
    .REFRESH_CYCLES     (REFRESH),
    .LAST_WORD_ADDR     (23'd15)
  ) ipod_top_i (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .cmd_valid           (cmd_valid),
    .cmd_ascii           (cmd_ascii),
    .key_speed_up        (key_speed_up),
    .key_speed_down      (key_speed_down),
    .key_speed_reset     (key_speed_reset),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample_valid        (sample_valid),
    .sample_data         (sample_data),
    .hex0                (hex0),
    .hex1                (hex1),
    .hex2                (hex2),
    .hex3                (hex3),
    .hex4                (hex4),
    .hex5                (hex5)
  );

  tb_flash_model flash_i (
    .CLK_50M         (CLK_50M),
    .rst_n           (rst_n),
    .read            (flash_read),
    .address         (flash_address),
    .waitrequest     (flash_waitrequest),
    .readdata        (flash_readdata),
    .readdatavalid   (flash_readdatavalid),
    .protocol_errors (protocol_errors)
  );

  // Active low, segment a in bit 0
  function automatic logic [6:0] seg_of(input logic [3:0] d);
    case (d)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  function automatic logic [41:0] display_of(input int hc);
    logic [41:0] s;
    logic [23:0] v;
    v = 24'(hc);
    for (int i = 0; i < 6; i++)
      s[7*i +: 7] = seg_of(v[4*i +: 4]);
    return s;
  endfunction

  // ========================================
  // Shadow of play position and direction
  // ========================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      exp_pos <= '0;
      tb_fwd <= 1'b1;
      tb_play <= 1'b0;
      ever_played <= 1'b0;
      rst_d1 <= 1'b0;
      fwd_d1 <= 1'b0;
      bwd_d1 <= 1'b0;
      gap <= 0;
      have_prev <= 1'b0;
      idle_cnt <= 0;
    end
    else
    begin
      rst_d1 <= cmd_valid && (cmd_ascii == ipod_pkg::CMD_RESTART);
      fwd_d1 <= cmd_valid && (cmd_ascii == ipod_pkg::CMD_FORWARD);
      bwd_d1 <= cmd_valid && (cmd_ascii == ipod_pkg::CMD_BACKWARD);
      if (cmd_valid && cmd_ascii == ipod_pkg::CMD_PLAY)
      begin
        tb_play <= 1'b1;
        ever_played <= 1'b1;
      end
      if (cmd_valid && cmd_ascii == ipod_pkg::CMD_PAUSE)
        tb_play <= 1'b0;
      if (fwd_d1)
        tb_fwd <= 1'b1;
      if (bwd_d1)
        tb_fwd <= 1'b0;
      if (rst_d1)
        exp_pos <= tb_fwd ? 6'd0 : 6'd63;
      else if (sample_valid)
        exp_pos <= tb_fwd ? exp_pos + 1'b1 : exp_pos - 1'b1;
      gap <= sample_valid ? 1 : gap + 1;
      if (!steady)
        have_prev <= 1'b0;
      else if (sample_valid)
        have_prev <= 1'b1;
      idle_cnt <= tb_play ? 0 : idle_cnt + 1;
    end
  end

  assign gap_ok = !(sample_valid && steady && have_prev)
                  || ((gap >= 2 * tb_hc - 3) && (gap <= 2 * tb_hc + 3));

  // ========================================
  // Checks
  // ========================================
  sample_value: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    sample_valid |-> (sample_data == {2'b00, exp_pos}))
  else
  begin
    errors++;
    $display("[FAIL] %0t sample_data got %0d expected %0d", $time, sample_data, exp_pos);
  end

  sample_spacing: assert property (@(posedge CLK_50M) disable iff (!rst_n) gap_ok)
  else
  begin
    errors++;
    $display("[FAIL] %0t gap got %0d expected %0d", $time, gap, 2 * tb_hc);
  end

  // No samples before play, none long after pause
  sample_when_allowed: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    sample_valid |-> (tb_play || (ever_played && idle_cnt <= 2 * tb_hc)))
  else
  begin
    errors++;
    $display("A sample appeared at %0t while playback was stopped", $time);
  end

  display_value: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    disp_check |-> ({hex5, hex4, hex3, hex2, hex1, hex0} == display_of(tb_hc)))
  else
  begin
    errors++;
    $display("[FAIL] %0t hex5..hex0 got %h expected %h", $time,
             {hex5, hex4, hex3, hex2, hex1, hex0}, display_of(tb_hc));
  end

  // ========================================
  // Stimulus tasks
  // ========================================
  task automatic send_cmd(input logic [7:0] code);
    @(posedge CLK_50M);
    cmd_valid <= 1'b1;
    cmd_ascii <= code;
    @(posedge CLK_50M);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_samples(input int n);
    int seen;
    seen = 0;
    while (seen < n)
    begin
      @(posedge CLK_50M);
      if (sample_valid)
        seen++;
    end
  endtask

  task automatic check_display();
    repeat (REFRESH + 2) @(posedge CLK_50M);
    disp_check <= 1'b1;
    @(posedge CLK_50M);
    disp_check <= 1'b0;
  endtask

  // Key held for held cycles gives one step plus one per REPEAT
  task automatic hold_key(input int which, input int held);
    int steps;
    steps = 1 + (held - 1) / REPEAT;
    @(posedge CLK_50M);
    case (which)
      0: key_speed_up <= 1'b1;
      1: key_speed_down <= 1'b1;
      default: key_speed_reset <= 1'b1;
    endcase
    repeat (held) @(posedge CLK_50M);
    key_speed_up <= 1'b0;
    key_speed_down <= 1'b0;
    key_speed_reset <= 1'b0;
    for (int i = 0; i < steps; i++)
    begin
      if (which == 0)
        tb_hc = (tb_hc < HC_MIN + STEP) ? HC_MIN : tb_hc - STEP;
      else if (which == 1)
        tb_hc = (tb_hc > HC_MAX - STEP) ? HC_MAX : tb_hc + STEP;
      else
        tb_hc = HC0;
    end
  endtask

  always @(posedge CLK_50M)
  begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  initial
  begin
    rst_n = 1'b0;
    cmd_valid = 1'b0;
    cmd_ascii = 8'h00;
    key_speed_up = 1'b0;
    key_speed_down = 1'b0;
    key_speed_reset = 1'b0;
    repeat (5) @(posedge CLK_50M);
    rst_n <= 1'b1;
    repeat (REFRESH + 2) @(posedge CLK_50M);
    disp_check <= 1'b1;
    @(posedge CLK_50M);
    disp_check <= 1'b0;

    hold_key(0, 1);
    check_display();
    hold_key(0, 4 * REPEAT + 100);
    check_display();

    send_cmd(ipod_pkg::CMD_PLAY);
    wait_samples(2);
    steady <= 1'b1;
    wait_samples(70);
    send_cmd(ipod_pkg::CMD_BACKWARD);
    wait_samples(70);

    steady <= 1'b0;
    send_cmd(ipod_pkg::CMD_RESTART);
    wait_samples(10);
    send_cmd(ipod_pkg::CMD_FORWARD);
    send_cmd(ipod_pkg::CMD_RESTART);
    wait_samples(6);
    // Restart with a read in flight
    while (!flash_read)
      @(posedge CLK_50M);
    send_cmd(ipod_pkg::CMD_RESTART);
    wait_samples(3);
    steady <= 1'b1;
    wait_samples(6);

    steady <= 1'b0;
    send_cmd(ipod_pkg::CMD_PAUSE);
    repeat (150) @(posedge CLK_50M);
    // Short hold that stops before the limit shows the repeat rate
    hold_key(1, 3 * REPEAT + 100);
    check_display();
    hold_key(1, 8 * REPEAT + 100);
    check_display();
    hold_key(2, 1);
    check_display();
    repeat (5) @(posedge CLK_50M);

    $display("Errors: %0d check, %0d protocol", errors, protocol_errors);
    if (errors == 0 && protocol_errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
ipod_pkg.sv
player_if.sv
player_control.sv
speed_regulator.sv
sample_tick_gen.sv
flash_sample_fetcher.sv
display_refresh.sv
hex_digit_decoder.sv
ipod_top.sv
tb_flash_model.sv
tb_ipod.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f files.f --top-module tb_ipod -o sim_ipod
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_ipod > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error"
  cat sim.log
  exit 1
fi

cat sim.log
if grep -q "\*\* PASS \*\*" sim.log; then
  exit 0
else
  exit 1
fi
